// File: Bender.yml
package:
  name: pc_unit

sources:
  - include_dirs:
      - hw
    files:
      - hw/pc_isa_pkg.sv
      - hw/pc_ctrl_pkg.sv
      - hw/ser_add.sv
      - hw/shift_reg.sv
      - hw/jal_imm_ser.sv
      - hw/pc_ctrl.sv
      - hw/pc_unit_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - testbench/pc_unit_asserts.sv
      - testbench/pc_unit_tb.sv

// File: compile.f
+incdir+hw
hw/pc_isa_pkg.sv
hw/pc_ctrl_pkg.sv
hw/ser_add.sv
hw/shift_reg.sv
hw/jal_imm_ser.sv
hw/pc_ctrl.sv
hw/pc_unit_top.sv
testbench/pc_unit_asserts.sv
testbench/pc_unit_tb.sv

// File: hw/jal_imm_ser.sv
`timescale 1ns/1ps

module jal_imm_ser
   import pc_isa_pkg::*;
   import pc_ctrl_pkg::*;
(
   input  logic    clk,
   input  logic    i_rst,
   input  logic    i_load,
   input  instr_t  i_instr,
   input  pc_ctl_t i_ctl,
   output logic    o_offset
);

   // ====================
   // Field registers
   // ====================

   logic [9:0] imm10_1_q;
   logic       imm11_q;
   logic [7:0] imm19_12_q;
   logic       sign_q;

   always_ff @(posedge clk) begin
      if (i_rst) begin
         imm10_1_q  <= '0;
         imm11_q    <= 1'b0;
         imm19_12_q <= '0;
         sign_q     <= 1'b0;
      end else if (i_load) begin
         imm10_1_q  <= i_instr.imm10_1;
         imm11_q    <= i_instr.imm11;
         imm19_12_q <= i_instr.imm19_12;
         sign_q     <= i_instr.sign;
      end else if (i_ctl.shift_en) begin
         // Only the field in use moves, the others wait for their turn
         case (i_ctl.off_src)
            OFF_INSTR: begin
               imm10_1_q <= {1'b0, imm10_1_q[9:1]};
            end
            OFF_REG2012: begin
               imm19_12_q <= {1'b0, imm19_12_q[7:1]};
            end
            default: begin
            end
         endcase
      end
   end

   // ====================
   // Offset bit
   // ====================

   // imm11 is a single bit and sign is replicated, neither has to shift
   always_comb begin
      case (i_ctl.off_src)
         OFF_INSTR: begin
            o_offset = imm10_1_q[0];
         end
         OFF_REG11: begin
            o_offset = imm11_q;
         end
         OFF_REG2012: begin
            o_offset = imm19_12_q[0];
         end
         OFF_SIGN: begin
            o_offset = sign_q;
         end
         default: begin
            o_offset = 1'b0;
         end
      endcase
   end

endmodule

// File: hw/pc_config.svh
`ifndef PC_CONFIG_SVH
`define PC_CONFIG_SVH

// ====================
// PC unit configuration
// ====================

// Width of the program counter and of every serial word
`define PC_WIDTH 32

// Address offered on the PC port right after reset
`define PC_RESET_VALUE 32'h0000_0008

`endif

// File: hw/pc_ctrl.sv
`timescale 1ns/1ps
`include "pc_config.svh"

module pc_ctrl
   import pc_isa_pkg::*;
   import pc_ctrl_pkg::*;
(
   input  logic    clk,
   input  logic    i_rst,
   input  logic    i_go,
   input  opcode_e i_opcode,
   input  logic    i_pc_ready,
   output pc_ctl_t o_ctl,
   output logic    o_load,
   output logic    o_rd_valid,
   output logic    o_pc_valid
);

   localparam logic [4:0] LAST_BIT = 5'(`PC_WIDTH - 1);

   pc_state_e state_q;
   pc_state_e state_d;
   logic [4:0] cnt_q;
   logic       jal_q;
   logic       running;
   off_src_e   off_src;

   assign running = (state_q == ST_RUN);

   // Go is only taken while idle, anything else is dropped
   assign o_load = (state_q == ST_IDLE) && i_go;

   // ====================
   // FSM
   // ====================

   always_comb begin
      state_d = state_q;
      case (state_q)
         ST_IDLE: begin
            if (i_go) begin
               state_d = ST_RUN;
            end
         end
         ST_RUN: begin
            if (cnt_q == LAST_BIT) begin
               state_d = ST_DONE;
            end
         end
         ST_DONE: begin
            state_d = ST_OFFER;
         end
         default: begin
            if (i_pc_ready) begin
               state_d = ST_IDLE;
            end
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (i_rst) begin
         // Reset PC is offered straight away
         state_q <= ST_OFFER;
         cnt_q   <= '0;
         jal_q   <= 1'b0;
      end else begin
         state_q <= state_d;
         cnt_q   <= running ? cnt_q + 5'd1 : 5'd0;
         if (o_load) begin
            jal_q <= (i_opcode == OP_JAL);
         end
      end
   end

   // ====================
   // Control bundle
   // ====================

   // Bit position picks which J-immediate field is on the offset input
   always_comb begin
      off_src = OFF_NONE;
      if (running && jal_q) begin
         if (cnt_q == 5'd0) begin
            off_src = OFF_NONE;
         end else if (cnt_q <= 5'd10) begin
            off_src = OFF_INSTR;
         end else if (cnt_q == 5'd11) begin
            off_src = OFF_REG11;
         end else if (cnt_q <= 5'd19) begin
            off_src = OFF_REG2012;
         end else begin
            off_src = OFF_SIGN;
         end
      end
   end

   always_comb begin
      o_ctl.shift_en   = running;
      o_ctl.add4_bit   = running && (cnt_q == 5'd2);
      o_ctl.clr        = !running;
      o_ctl.sel_offset = running && jal_q;
      o_ctl.off_src    = off_src;
   end

   assign o_rd_valid = running && jal_q;
   assign o_pc_valid = (state_q == ST_OFFER);

endmodule

// File: hw/pc_ctrl_pkg.sv
package pc_ctrl_pkg;

   // ====================
   // Controller states
   // ====================

   typedef enum logic [1:0] {
      ST_IDLE  = 2'd0,
      ST_RUN   = 2'd1,
      ST_DONE  = 2'd2,
      ST_OFFER = 2'd3
   } pc_state_e;

   // Immediate field that feeds the offset adder in the current bit
   typedef enum logic [2:0] {
      OFF_NONE    = 3'd0,
      OFF_INSTR   = 3'd1,
      OFF_REG11   = 3'd2,
      OFF_REG2012 = 3'd3,
      OFF_SIGN    = 3'd4
   } off_src_e;

   // ====================
   // Control bundle
   // ====================

   // Sent from the controller to the serial datapath every cycle
   typedef struct packed {
      logic     shift_en;
      logic     add4_bit;
      logic     clr;
      logic     sel_offset;
      off_src_e off_src;
   } pc_ctl_t;

endpackage

// File: hw/pc_isa_pkg.sv
package pc_isa_pkg;

   // ====================
   // Opcodes
   // ====================

   // Major opcodes seen by the PC unit, only JAL changes the flow here
   typedef enum logic [6:0] {
      OP_JAL    = 7'b110_1111,
      OP_JALR   = 7'b110_0111,
      OP_BRANCH = 7'b110_0011,
      OP_OP_IMM = 7'b001_0011,
      OP_OTHER  = 7'b000_0000
   } opcode_e;

   // ====================
   // Instruction fields
   // ====================

   // J-type layout
   // The immediate is {sign x12, imm19_12, imm11, imm10_1, 1'b0}
   typedef struct packed {
      logic       sign;
      logic [9:0] imm10_1;
      logic       imm11;
      logic [7:0] imm19_12;
      logic [4:0] rd;
      opcode_e    opcode;
   } instr_t;

endpackage

// File: hw/pc_unit_top.sv
`timescale 1ns/1ps
`include "pc_config.svh"

module pc_unit_top
   import pc_isa_pkg::*;
   import pc_ctrl_pkg::*;
(
   input  logic                 clk,
   input  logic                 i_rst,
   input  logic                 i_go,
   input  logic [31:0]          i_instr,
   input  logic                 i_pc_ready,
   output logic [`PC_WIDTH-1:0] o_pc_data,
   output logic                 o_pc_valid,
   output logic                 o_rd,
   output logic                 o_rd_valid
);

   instr_t               instr;
   pc_ctl_t              ctl;
   logic                 load;
   logic                 pc_bit;
   logic [`PC_WIDTH-1:1] pc_par;
   logic                 offset_bit;
   logic                 plus4_sum;
   logic                 off_sum;
   logic                 new_pc_bit;

   assign instr = instr_t'(i_instr);

   pc_ctrl ctrl_i (
      .clk        (clk),
      .i_rst      (i_rst),
      .i_go       (i_go),
      .i_opcode   (instr.opcode),
      .i_pc_ready (i_pc_ready),
      .o_ctl      (ctl),
      .o_load     (load),
      .o_rd_valid (o_rd_valid),
      .o_pc_valid (o_pc_valid)
   );

   jal_imm_ser imm_ser_i (
      .clk      (clk),
      .i_rst    (i_rst),
      .i_load   (load),
      .i_instr  (instr),
      .i_ctl    (ctl),
      .o_offset (offset_bit)
   );

   // ====================
   // Serial datapath
   // ====================

   ser_add pc_plus_4_add (
      .clk   (clk),
      .i_rst (i_rst),
      .i_a   (ctl.add4_bit),
      .i_b   (pc_bit),
      .i_clr (ctl.clr),
      .o_q   (plus4_sum)
   );

   ser_add pc_plus_off_add (
      .clk   (clk),
      .i_rst (i_rst),
      .i_a   (pc_bit),
      .i_b   (offset_bit),
      .i_clr (ctl.clr),
      .o_q   (off_sum)
   );

   // JAL takes the jump target, everything else falls through
   assign new_pc_bit = ctl.sel_offset ? off_sum : plus4_sum;

   shift_reg #(
      .LEN  (`PC_WIDTH),
      .INIT (`PC_RESET_VALUE)
   ) pc_reg (
      .clk   (clk),
      .i_rst (i_rst),
      .i_en  (ctl.shift_en),
      .i_d   (new_pc_bit),
      .o_q   (pc_bit),
      .o_par (pc_par)
   );

   assign o_pc_data = {pc_par, pc_bit};

   // Link value for rd is the fall-through address
   assign o_rd = plus4_sum;

endmodule

// File: hw/ser_add.sv
`timescale 1ns/1ps

module ser_add (
   input  logic clk,
   input  logic i_rst,
   input  logic i_a,
   input  logic i_b,
   input  logic i_clr,
   output logic o_q
);

   logic carry_q;
   logic carry_d;

   // Full adder on the current bit pair and the carry from the previous bit
   assign o_q     = i_a ^ i_b ^ carry_q;
   assign carry_d = (i_a & i_b) | (i_a & carry_q) | (i_b & carry_q);

   always_ff @(posedge clk) begin
      if (i_rst) begin
         carry_q <= 1'b0;
      end else if (i_clr) begin
         // Start of a new word, no carry into bit 0
         carry_q <= 1'b0;
      end else begin
         carry_q <= carry_d;
      end
   end

endmodule

// File: hw/shift_reg.sv
`timescale 1ns/1ps

module shift_reg #(
   parameter int             LEN  = 32,
   parameter logic [LEN-1:0] INIT = '0
) (
   input  logic           clk,
   input  logic           i_rst,
   input  logic           i_en,
   input  logic           i_d,
   output logic           o_q,
   output logic [LEN-1:1] o_par
);

   logic [LEN-1:0] sr_q;

   // New bits enter at the top, the LSB leaves first
   // After LEN shifts the old word has been fully replaced
   always_ff @(posedge clk) begin
      if (i_rst) begin
         sr_q <= INIT;
      end else if (i_en) begin
         sr_q <= {i_d, sr_q[LEN-1:1]};
      end
   end

   assign o_q   = sr_q[0];
   assign o_par = sr_q[LEN-1:1];

endmodule

// File: testbench/pc_unit_asserts.sv
`timescale 1ns/1ps

module pc_unit_asserts
   import pc_ctrl_pkg::*;
(
   input logic      clk,
   input logic      i_rst,
   input logic      i_go,
   input logic      i_pc_ready,
   input pc_state_e state_q,
   input pc_ctl_t   o_ctl,
   input logic      o_load,
   input logic      o_pc_valid
);

   int fail_cnt = 0;

   // An offered PC stays offered and the PC register stays still until it is taken
   a_offer_hold: assert property (@(posedge clk) disable iff (i_rst)
      o_pc_valid && !i_pc_ready |=> o_pc_valid && !o_ctl.shift_en)
   else begin
      fail_cnt++;
      $error("PC offer changed while i_pc_ready was low");
   end

   // One bit per cycle, so a run is exactly one word long
   a_run_len: assert property (@(posedge clk) disable iff (i_rst)
      (state_q == ST_IDLE) && i_go |=> (state_q == ST_RUN) [*32] ##1 (state_q == ST_DONE))
   else begin
      fail_cnt++;
      $error("Run phase did not last 32 cycles");
   end

   // Every run starts from a go taken in idle, so the immediate is always fresh
   a_load_idle: assert property (@(posedge clk) disable iff (i_rst)
      $rose(state_q == ST_RUN) |-> $past(o_load))
   else begin
      fail_cnt++;
      $error("ST_RUN entered without o_load from ST_IDLE");
   end

endmodule

bind pc_ctrl pc_unit_asserts asserts_i (.*);

// File: testbench/pc_unit_tb.sv
`timescale 1ns/1ps
`include "pc_config.svh"

module pc_unit_tb
   import pc_isa_pkg::*;
();

   localparam int RUN_TIMEOUT = 60;

   logic        clk;
   logic        i_rst;
   logic        i_go;
   logic [31:0] i_instr;
   logic        i_pc_ready;
   logic [31:0] o_pc_data;
   logic        o_pc_valid;
   logic        o_rd;
   logic        o_rd_valid;

   logic [31:0] model_pc;
   int          errors;
   int          checks;
   int          test_errors;
   int          test_ops;
   int          tests_run;
   int          tests_bad;
   bit          timed_out;

   pc_unit_top dut_i (
      .clk        (clk),
      .i_rst      (i_rst),
      .i_go       (i_go),
      .i_instr    (i_instr),
      .i_pc_ready (i_pc_ready),
      .o_pc_data  (o_pc_data),
      .o_pc_valid (o_pc_valid),
      .o_rd       (o_rd),
      .o_rd_valid (o_rd_valid)
   );

   initial begin
      clk = 1'b0;
      forever begin
         #10 clk = ~clk;
      end
   end

   // ====================
   // Helpers
   // ====================

   task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
      checks++;
      if (act !== exp) begin
         $display("ERR %s expected %h got %h", name, exp, act);
         errors++;
         test_errors++;
      end
   endtask

   // J-type encoding straight from the ISA manual
   function automatic logic [31:0] jal_word(input logic [20:0] imm, input logic [4:0] rd);
      return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b110_1111};
   endfunction

   function automatic logic [20:0] rand_imm();
      logic [20:0] imm;
      imm = 21'($urandom);
      imm[0] = 1'b0;
      return imm;
   endfunction

   function automatic logic [31:0] other_word();
      logic [31:0] w;
      w = $urandom;
      case ($urandom_range(3))
         0: w[6:0] = OP_JALR;
         1: w[6:0] = OP_BRANCH;
         2: w[6:0] = OP_OP_IMM;
         default: w[6:0] = OP_OTHER;
      endcase
      return w;
   endfunction

   // Ready is high for a single cycle, so exactly one transfer happens
   task automatic accept_pc();
      @(posedge clk);
      #1;
      i_go = 1'b0;
      i_pc_ready = 1'b1;
      @(posedge clk);
      #1;
      i_pc_ready = 1'b0;
      @(negedge clk);
      check_value("o_pc_valid", 32'd0, o_pc_valid);
   endtask

   task automatic run_op(input logic [31:0] instr, input bit is_jal, input logic [20:0] imm,
                         input int hold, input bit extra_go);
      logic [31:0] exp_pc;
      logic [31:0] rd_word;
      int          cycles;
      int          rd_cnt;
      int          h;
      bit          done;
      exp_pc = is_jal ? model_pc + {{11{imm[20]}}, imm} : model_pc + 32'd4;
      rd_word = '0;
      rd_cnt = 0;
      done = 1'b0;
      @(posedge clk);
      #1;
      i_go = 1'b1;
      i_instr = instr;
      @(posedge clk);
      #1;
      i_go = 1'b0;
      i_instr = $urandom;
      cycles = 1;
      while (!done && !timed_out) begin
         @(negedge clk);
         if (o_pc_valid) begin
            done = 1'b1;
         end else if (cycles >= RUN_TIMEOUT) begin
            $display("Timeout: no valid PC within %0d cycles of i_go", RUN_TIMEOUT);
            timed_out = 1'b1;
            errors++;
            test_errors++;
         end else begin
            if (o_rd_valid) begin
               if (rd_cnt < 32) begin
                  rd_word[rd_cnt] = o_rd;
               end
               rd_cnt++;
            end
            @(posedge clk);
            cycles++;
         end
      end
      if (done) begin
         check_value("pc_valid_latency", 32'd34, cycles);
         check_value("o_pc_data", exp_pc, o_pc_data);
         check_value("rd_valid_cycles", is_jal ? 32'd32 : 32'd0, rd_cnt);
         if (is_jal) begin
            check_value("o_rd", model_pc + 32'd4, rd_word);
         end
         // A go pulse during back-pressure carries a JAL that must be ignored
         for (h = 0; h < hold; h++) begin
            @(posedge clk);
            #1;
            i_go = extra_go && (h == 0);
            i_instr = jal_word(rand_imm(), 5'd1);
            @(negedge clk);
            check_value("o_pc_valid", 32'd1, o_pc_valid);
            check_value("o_pc_data", exp_pc, o_pc_data);
            check_value("o_rd_valid", 32'd0, o_rd_valid);
         end
         accept_pc();
      end
      model_pc = exp_pc;
      test_ops++;
   endtask

   task automatic finish_test(input string name);
      tests_run++;
      if (test_errors != 0) begin
         tests_bad++;
      end
      $display("%-14s ops %0d  errors %0d", name, test_ops, test_errors);
      test_errors = 0;
      test_ops = 0;
   endtask

   // ====================
   // Test sequence
   // ====================

   initial begin
      int          i;
      int          total;
      bit          jal;
      logic [20:0] imm;
      logic [20:0] edge_imm [4];
      void'($urandom(32'h3483));
      edge_imm = '{21'h10_0000, 21'h0F_FFFE, 21'h00_0000, 21'h1F_FFFE};
      errors = 0;
      checks = 0;
      test_errors = 0;
      test_ops = 0;
      tests_run = 0;
      tests_bad = 0;
      timed_out = 1'b0;
      i_rst = 1'b1;
      i_go = 1'b0;
      i_instr = '0;
      i_pc_ready = 1'b0;
      model_pc = `PC_RESET_VALUE;
      repeat (4) @(posedge clk);
      #1;
      i_rst = 1'b0;
      @(negedge clk);

      check_value("o_pc_valid", 32'd1, o_pc_valid);
      check_value("o_pc_data", `PC_RESET_VALUE, o_pc_data);
      check_value("o_rd_valid", 32'd0, o_rd_valid);
      accept_pc();
      finish_test("reset");

      for (i = 0; i < 40 && !timed_out; i++) begin
         run_op(other_word(), 1'b0, '0, 0, 1'b0);
      end
      finish_test("fall_through");

      for (i = 0; i < 40 && !timed_out; i++) begin
         imm = rand_imm();
         run_op(jal_word(imm, 5'($urandom)), 1'b1, imm, 0, 1'b0);
      end
      finish_test("jal");

      for (i = 0; i < 12 && !timed_out; i++) begin
         jal = 1'($urandom_range(1));
         imm = rand_imm();
         run_op(jal ? jal_word(imm, 5'd5) : other_word(), jal, imm, $urandom_range(1, 16), 1'b1);
      end
      finish_test("back_pressure");

      // Extreme offsets, including the most negative one
      for (i = 0; i < 4 && !timed_out; i++) begin
         run_op(jal_word(edge_imm[i], 5'd1), 1'b1, edge_imm[i], 0, 1'b0);
      end
      finish_test("timing");

      total = errors + pc_unit_tb.dut_i.ctrl_i.asserts_i.fail_cnt;
      $display("Summary: tests %0d, tests with errors %0d, checks %0d, mismatches %0d, total %0d",
               tests_run, tests_bad, checks, errors, total);
      if (total == 0 && !timed_out) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule
